// File: rtl/mac_pkg.sv
`default_nettype none

package mac_pkg;

    // One input operand
    typedef logic signed [15:0] operand_t;

    // Product and running sum share one width
    typedef logic signed [31:0] acc_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,        // Operands captured
        ACCUMULATE,  // Product folded into the sum
        ACK_HOLD,    // Waiting for req to drop
        DONE         // One-cycle completion strobe
    } mac_state_t;

endpackage

`default_nettype wire

// File: rtl/mac_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mac_ctrl_if;

    logic load_operands; // Capture a and b
    logic accumulate;    // Update sum and sticky flag
    logic hold_result;   // Leave all datapath state alone
    logic done;          // Vector complete, copy to outputs

    modport fsm (
        output load_operands,
        output accumulate,
        output hold_result,
        output done
    );

    modport datapath (
        input load_operands,
        input accumulate,
        input hold_result,
        input done
    );

endinterface

`default_nettype wire

// File: rtl/mac_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mac_fsm (
    input  logic   clk,
    input  logic   reset,
    input  logic   req,
    input  logic   last_term,
    output logic   ack,
    output logic   step,
    mac_ctrl_if.fsm ctrl
);
    import mac_pkg::*;

    mac_state_t state;
    mac_state_t next_state;
    logic       vector_end; // Last pair seen in ACCUMULATE

    // The counter advances on the step edge, so its view of the
    // last pair is kept here for the exit from ACK_HOLD
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vector_end <= 1'b0;
        end else if (state == ACCUMULATE) begin
            vector_end <= last_term;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (req) begin
                    next_state = LOAD;
                end
            end
            LOAD:       next_state = ACCUMULATE;
            ACCUMULATE: next_state = ACK_HOLD;
            ACK_HOLD: begin
                // Slow release just keeps us here
                if (!req) begin
                    next_state = vector_end ? DONE : IDLE;
                end
            end
            DONE:       next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    // Strobes decoded straight from the state register
    assign ctrl.load_operands = (state == LOAD);
    assign ctrl.accumulate    = (state == ACCUMULATE);
    assign ctrl.done          = (state == DONE);
    assign ctrl.hold_result   = (state == IDLE) || (state == ACK_HOLD) || (state == DONE);

    assign step = (state == ACCUMULATE);
    assign ack  = (state == ACK_HOLD);

endmodule

`default_nettype wire

// File: rtl/term_counter.sv
`timescale 1ns/1ps
`default_nettype none

module term_counter #(
    parameter int vector_length = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic step,
    output logic first_term,
    output logic last_term
);

    // At least one bit, even for single-pair vectors
    localparam int count_width = (vector_length > 1) ? $clog2(vector_length) : 1;

    typedef logic [count_width-1:0] count_t;

    localparam count_t last_count = count_t'(vector_length - 1);

    count_t count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (step) begin
            if (last_term) begin
                count <= '0; // Wrap for the next vector
            end else begin
                count <= count + count_t'(1);
            end
        end
    end

    assign first_term = (count == '0);
    assign last_term  = (count == last_count); // Both high when vector_length is 1

endmodule

`default_nettype wire

// File: rtl/mac_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module mac_datapath (
    input  logic              clk,
    input  logic              reset,
    input  logic              first_term,
    input  mac_pkg::operand_t a,
    input  mac_pkg::operand_t b,
    mac_ctrl_if.datapath      ctrl,
    output mac_pkg::acc_t     result,
    output logic              overflow
);
    import mac_pkg::*;

    operand_t a_q;
    operand_t b_q;
    acc_t     product;
    acc_t     acc;
    acc_t     sum;
    acc_t     result_q;
    logic     sticky_ovf;
    logic     result_ovf_q;
    logic     add_ovf;
    logic     acc_en;

    // Operand capture, payload only
    always_ff @(posedge clk) begin
        if (ctrl.load_operands) begin
            a_q <= a;
            b_q <= b;
        end
    end

    assign product = a_q * b_q; // Full 32-bit signed product
    assign sum     = acc + product;

    // Same-sign addends with a sum of the other sign
    assign add_ovf = (acc[31] == product[31]) && (sum[31] != acc[31]);

    assign acc_en = ctrl.accumulate && !ctrl.hold_result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc        <= '0;
            sticky_ovf <= 1'b0;
        end else if (acc_en) begin
            if (first_term) begin
                acc        <= product; // New vector starts from its own product
                sticky_ovf <= 1'b0;
            end else begin
                acc        <= sum;     // Wraps, no saturation
                sticky_ovf <= sticky_ovf | add_ovf;
            end
        end
    end

    // Output copy so the next vector can run underneath
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_q     <= '0;
            result_ovf_q <= 1'b0;
        end else if (ctrl.done) begin
            result_q     <= acc;
            result_ovf_q <= sticky_ovf;
        end
    end

    // Bypass makes the sum visible in the done cycle itself
    assign result   = ctrl.done ? acc : result_q;
    assign overflow = ctrl.done ? sticky_ovf : result_ovf_q;

endmodule

`default_nettype wire

// File: rtl/mac_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit #(
    parameter int vector_length = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  mac_pkg::operand_t a,
    input  mac_pkg::operand_t b,
    output logic              ack,
    output logic              done,
    output logic              overflow,
    output mac_pkg::acc_t     result
);

    logic step;
    logic first_term;
    logic last_term;

    mac_ctrl_if ctrl_if ();

    mac_fsm fsm_i (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .last_term (last_term),
        .ack       (ack),
        .step      (step),
        .ctrl      (ctrl_if.fsm)
    );

    term_counter #(
        .vector_length (vector_length)
    ) counter_i (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .first_term (first_term),
        .last_term  (last_term)
    );

    mac_datapath datapath_i (
        .clk        (clk),
        .reset      (reset),
        .first_term (first_term),
        .a          (a),
        .b          (b),
        .ctrl       (ctrl_if.datapath),
        .result     (result),
        .overflow   (overflow)
    );

    assign done = ctrl_if.done; // Completion strobe straight from the FSM

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Power-on reset, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: bench/mac_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit_assertions (
    input logic          clk,
    input logic          reset,
    input logic          req,
    input logic          ack,
    input logic          done,
    input logic          overflow,
    input mac_pkg::acc_t result
);

    int fail_count = 0; // Assertion failures, summed into the testbench total

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack rose while req was low");
            fail_count++;
        end

    ack_held: assert property (@(posedge clk) disable iff (reset)
        (ack && req) |=> ack)
        else begin
            $error("ack fell before req was released");
            fail_count++;
        end

    done_single: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else begin
            $error("done lasted more than one cycle");
            fail_count++;
        end

    // Outputs only move in a done cycle
    outputs_stable: assert property (@(posedge clk) disable iff (reset)
        !done |-> ($stable(result) && $stable(overflow)))
        else begin
            $error("result or overflow changed outside a done cycle");
            fail_count++;
        end

endmodule

bind mac_unit mac_unit_assertions assertions_i (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .ack      (ack),
    .done     (done),
    .overflow (overflow),
    .result   (result)
);

`default_nettype wire

// File: bench/mac_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit_tb;
    import mac_pkg::*;

    localparam int vector_length   = 4;
    localparam int total_pairs     = 14 * vector_length + 3;
    localparam int watchdog_cycles = total_pairs * 12 + 100;
    localparam int handshake_limit = 20;

    logic     clk;
    logic     por_reset;
    logic     test_reset;
    logic     reset;
    logic     req;
    operand_t a;
    operand_t b;
    logic     ack;
    logic     done;
    logic     overflow;
    acc_t     result;

    operand_t vec_a [vector_length];
    operand_t vec_b [vector_length];
    int       error_count;
    int       check_count;
    int       done_count;

    assign reset = por_reset || test_reset;

    tb_clock #(.period_ns(40), .reset_cycles(4)) clock_i (.clk(clk), .reset(por_reset));

    mac_unit #(.vector_length(vector_length)) mac_unit_i (
        .clk(clk), .reset(reset), .req(req), .a(a), .b(b),
        .ack(ack), .done(done), .overflow(overflow), .result(result)
    );

    always @(posedge clk) begin
        if (!reset && done) begin
            done_count++; // One count per pulse
        end
    end

    task automatic check_result(input string name, input acc_t got, input acc_t expected);
        check_count++;
        if (got !== expected) begin
            $display("Fail %s: got 0x%08h expected 0x%08h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Full precision products, wrap to 32 bits, overflow on any partial sum
    function automatic void model_vector(output acc_t sum, output logic ovf);
        longint wide;
        sum = '0;
        ovf = 1'b0;
        for (int i = 0; i < vector_length; i++) begin
            wide = longint'(vec_a[i]) * longint'(vec_b[i]);
            if (i > 0) begin
                wide = longint'(sum) + wide;
            end
            if (wide != longint'(acc_t'(wide))) begin
                ovf = 1'b1;
            end
            sum = acc_t'(wide);
        end
    endfunction

    task automatic fill_small();
        logic signed [7:0] ra;
        logic signed [7:0] rb;
        for (int i = 0; i < vector_length; i++) begin
            ra = $urandom;
            rb = $urandom;
            vec_a[i] = operand_t'(ra);
            vec_b[i] = operand_t'(rb);
        end
    endtask

    // Mode 0 is all most-negative, mode 1 mixes both extremes
    task automatic fill_extreme(input int mode);
        for (int i = 0; i < vector_length; i++) begin
            vec_a[i] = (mode == 0 || $urandom_range(1) == 0) ? 16'sh8000 : 16'sh7fff;
            vec_b[i] = (mode == 0 || $urandom_range(1) == 0) ? 16'sh8000 : 16'sh7fff;
        end
    endtask

    // Called on a falling edge, returns on the falling edge that sees ack low
    task automatic send_pair(input operand_t pa, input operand_t pb, input int hold);
        int waited;
        req = 1'b1;
        a = pa;
        b = pb;
        waited = 0;
        while (!ack && waited < handshake_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            $display("ack never rose for the pair 0x%04h, 0x%04h", pa, pb);
            error_count++;
        end
        repeat (hold) begin
            @(negedge clk);
            if (!ack) begin
                $display("ack dropped while req was still high");
                error_count++;
            end
        end
        req = 1'b0;
        waited = 0;
        while (ack && waited < handshake_limit) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            $display("ack stayed high after req was released");
            error_count++;
        end
    endtask

    task automatic run_vector(input int gap_max, input int hold_max);
        acc_t exp_sum;
        logic exp_ovf;
        int   waited;
        model_vector(exp_sum, exp_ovf);
        for (int i = 0; i < vector_length; i++) begin
            send_pair(vec_a[i], vec_b[i], $urandom_range(hold_max));
            if (i < vector_length - 1) begin
                idle_cycles($urandom_range(gap_max));
            end
        end
        waited = 0;
        while (!done && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("done did not pulse after the last pair of a vector");
            error_count++;
        end else begin
            check_result("result", result, exp_sum);
            check_flag("overflow", overflow, exp_ovf);
        end
        idle_cycles($urandom_range(gap_max));
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("Test %s: %s", name, (error_count == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        int start;
        int done_start;
        req = 1'b0;
        a = '0;
        b = '0;
        test_reset = 1'b0;
        error_count = 0;
        check_count = 0;
        done_count = 0;
        void'($urandom(32'h39f3_f758));
        @(negedge clk);
        while (reset) @(negedge clk);

        start = error_count;
        repeat (3) begin
            fill_small();
            run_vector(3, 0);
        end
        report_test("small_operands", start);

        start = error_count;
        fill_extreme(0); // Four times 2**30 wraps to zero
        run_vector(3, 0);
        fill_extreme(1);
        run_vector(3, 0);
        report_test("extreme_operands", start);

        start = error_count;
        idle_cycles(1);
        done_start = done_count;
        fill_extreme(0); // Overflow set, then cleared by the next vector
        run_vector(0, 0);
        repeat (3) begin
            fill_small();
            run_vector(0, 0);
        end
        idle_cycles(1);
        if (done_count - done_start != 4) begin
            $display("Saw %0d done pulses for 4 vectors", done_count - done_start);
            error_count++;
        end
        report_test("back_to_back", start);

        start = error_count;
        repeat (3) begin
            fill_small();
            run_vector(3, 4);
        end
        report_test("slow_release", start);

        start = error_count;
        fill_extreme(0);
        vec_b[vector_length - 1] = '0; // Three times 2**30 wraps to a non-zero sum
        run_vector(3, 0);
        fill_small();
        send_pair(vec_a[0], vec_b[0], 0);
        idle_cycles($urandom_range(3));
        send_pair(vec_a[1], vec_b[1], 0);
        a = vec_a[2];
        b = vec_b[2];
        req = 1'b1;
        idle_cycles(3); // ack is up on the third falling edge
        check_flag("ack", ack, 1'b1);
        test_reset = 1'b1;
        idle_cycles(1);
        check_flag("ack", ack, 1'b0); // req still high here
        req = 1'b0;
        idle_cycles(1);
        test_reset = 1'b0;
        idle_cycles(1);
        check_flag("ack", ack, 1'b0);
        check_flag("done", done, 1'b0);
        check_result("result", result, '0);
        check_flag("overflow", overflow, 1'b0);
        fill_small();
        run_vector(3, 0);
        report_test("reset_mid_vector", start);

        error_count += mac_unit_i.assertions_i.fail_count;
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: mac_unit.f
rtl/mac_pkg.sv
rtl/mac_ctrl_if.sv
rtl/mac_fsm.sv
rtl/term_counter.sv
rtl/mac_datapath.sv
rtl/mac_unit.sv
bench/tb_clock.sv
bench/mac_unit_assertions.sv
bench/mac_unit_tb.sv

// File: Bender.yml
package:
  name: mac_unit

sources:
  - rtl/mac_pkg.sv
  - rtl/mac_ctrl_if.sv
  - rtl/mac_fsm.sv
  - rtl/term_counter.sv
  - rtl/mac_datapath.sv
  - rtl/mac_unit.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/mac_unit_assertions.sv
      - bench/mac_unit_tb.sv
